// ==== source/log_format_pkg.sv ====
package log_format_pkg;

    // operand and log word formats.
    localparam int operand_w = 16;
    localparam int log_int_w = 4;    // characteristic, the position of the leading one.
    localparam int log_frac_w = 12;  // mantissa bits kept below the leading one.
    localparam int log_w = log_int_w + log_frac_w;

    // field positions inside a log word, characteristic above mantissa.
    localparam int log_frac_lsb = 0;
    localparam int log_int_lsb = log_frac_w;

    // the extended log carries a sign and a carry bit above the characteristic.
    localparam int ext_log_w = 18;
    localparam int ext_int_w = ext_log_w - log_frac_w;

    // restored mantissa with its hidden one.
    localparam int mant_w = log_frac_w + 1;

    // signed shift amount in the antilog stage.
    localparam int shift_w = 7;

    // result formats.
    localparam int result_w = 32;
    localparam int quot_frac_w = 16;           // a quotient is unsigned 16.16.
    localparam int max_shift = result_w - 1;   // largest shift that still fits the result.
    localparam int wide_w = result_w + log_frac_w;

endpackage

// ==== source/muldiv_op_pkg.sv ====
package muldiv_op_pkg;

    // operation selected per sample.
    typedef enum logic {
        op_mul = 1'b0,  // a times b.
        op_div = 1'b1   // a divided by b.
    } op_e;

    // returned for a divide by zero and for a result that does not fit.
    localparam logic [31:0] sat_value = 32'hffff_ffff;

    // special-case codes carried between the two antilog registers.
    localparam int spec_w = 2;
    localparam logic [spec_w-1:0] spec_none = 2'd0;
    localparam logic [spec_w-1:0] spec_zero = 2'd1;
    localparam logic [spec_w-1:0] spec_dbz = 2'd2;
    localparam logic [spec_w-1:0] spec_ovf = 2'd3;

    // Only the divide-by-zero code raises the output flag.
    // Overflow saturates silently.

endpackage

// ==== source/stage1_log2_approx.sv ====
`timescale 1ns/1ps

module stage1_log2_approx (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  muldiv_op_pkg::op_e op,
    input  logic [log_format_pkg::operand_w-1:0] in_0,
    input  logic [log_format_pkg::operand_w-1:0] in_1,
    output logic valid_out,
    output muldiv_op_pkg::op_e op_out,
    output logic [log_format_pkg::log_w-1:0] log_in_0,
    output logic [log_format_pkg::operand_w-1:0] in_0_bypass,
    output logic [log_format_pkg::operand_w-1:0] in_1_bypass
);

    typedef logic [log_format_pkg::log_int_w-1:0] cnt_t;

    logic [2:0] valid_r;
    muldiv_op_pkg::op_e op_r0;
    muldiv_op_pkg::op_e op_r1;
    logic [log_format_pkg::operand_w-1:0] a_r0;
    logic [log_format_pkg::operand_w-1:0] b_r0;
    logic [log_format_pkg::operand_w-1:0] a_r1;
    logic [log_format_pkg::operand_w-1:0] b_r1;
    cnt_t lz_cnt;
    cnt_t lz_r1;
    logic [log_format_pkg::operand_w-1:0] a_norm;
    logic [log_format_pkg::log_w-1:0] log_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end else if (en) begin
            valid_r <= {valid_r[1:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op_r0 <= op;
            a_r0 <= in_0;
            b_r0 <= in_1;
            op_r1 <= op_r0;
            a_r1 <= a_r0;
            b_r1 <= b_r0;
            lz_r1 <= lz_cnt;
            op_out <= op_r1;
            log_in_0 <= log_next;
            in_0_bypass <= a_r1;
            in_1_bypass <= b_r1;
        end
    end

    // leading zero count, the highest set bit wins.
    always_comb begin
        lz_cnt = '1;  // a zero operand is flagged and cleared in stage 2.
        for (int i = 0; i < log_format_pkg::operand_w; i++) begin
            if (a_r0[i]) begin
                lz_cnt = cnt_t'(log_format_pkg::operand_w - 1 - i);
            end
        end
    end

    // after normalizing, the leading one sits in the top bit and the mantissa follows it.
    assign a_norm = a_r1 << lz_r1;
    assign log_next = {~lz_r1,
                       a_norm[log_format_pkg::operand_w-2 -: log_format_pkg::log_frac_w]};

    assign valid_out = valid_r[2];

endmodule

// ==== source/stage2_log2_operand_b.sv ====
`timescale 1ns/1ps

module stage2_log2_operand_b (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  muldiv_op_pkg::op_e op,
    input  logic [log_format_pkg::log_w-1:0] log_in_0,
    input  logic [log_format_pkg::operand_w-1:0] in_0,
    input  logic [log_format_pkg::operand_w-1:0] in_1,
    output logic valid_out,
    output muldiv_op_pkg::op_e op_out,
    output logic [log_format_pkg::log_w-1:0] log_a,
    output logic [log_format_pkg::log_w-1:0] log_b,
    output logic zero_a,
    output logic zero_b
);

    typedef logic [log_format_pkg::log_int_w-1:0] cnt_t;

    logic [1:0] valid_r;
    muldiv_op_pkg::op_e op_r0;
    logic [log_format_pkg::log_w-1:0] log_a_r0;
    logic [log_format_pkg::operand_w-1:0] b_r0;
    logic zero_a_r0;
    logic zero_b_r0;
    cnt_t lz_cnt;
    cnt_t lz_r0;
    logic [log_format_pkg::operand_w-1:0] b_norm;
    logic [log_format_pkg::log_w-1:0] log_b_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end else if (en) begin
            valid_r <= {valid_r[0], valid_in};
        end
    end

    // first register: count for b and zero flags from the raw operands.
    always_ff @(posedge clk) begin
        if (en) begin
            op_r0 <= op;
            log_a_r0 <= log_in_0;
            b_r0 <= in_1;
            lz_r0 <= lz_cnt;
            zero_a_r0 <= (in_0 == '0);
            zero_b_r0 <= (in_1 == '0);
        end
    end

    // second register: finished logs, zero operands forced to a log of 0.
    always_ff @(posedge clk) begin
        if (en) begin
            op_out <= op_r0;
            log_a <= zero_a_r0 ? '0 : log_a_r0;
            log_b <= zero_b_r0 ? '0 : log_b_next;
            zero_a <= zero_a_r0;
            zero_b <= zero_b_r0;
        end
    end

    always_comb begin
        lz_cnt = '1;
        for (int i = 0; i < log_format_pkg::operand_w; i++) begin
            if (in_1[i]) begin
                lz_cnt = cnt_t'(log_format_pkg::operand_w - 1 - i);
            end
        end
    end

    assign b_norm = b_r0 << lz_r0;
    assign log_b_next = {~lz_r0,
                         b_norm[log_format_pkg::operand_w-2 -: log_format_pkg::log_frac_w]};

    assign valid_out = valid_r[1];

endmodule

// ==== source/stage3_log_combine.sv ====
`timescale 1ns/1ps

module stage3_log_combine (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  muldiv_op_pkg::op_e op,
    input  logic [log_format_pkg::log_w-1:0] log_a,
    input  logic [log_format_pkg::log_w-1:0] log_b,
    input  logic zero_a,
    input  logic zero_b,
    output logic valid_out,
    output muldiv_op_pkg::op_e op_out,
    output logic signed [log_format_pkg::ext_log_w-1:0] ext_log,
    output logic zero_a_out,
    output logic zero_b_out
);

    localparam int pad_w = log_format_pkg::ext_log_w - log_format_pkg::log_w;

    logic [log_format_pkg::ext_log_w-1:0] log_a_ext;
    logic [log_format_pkg::ext_log_w-1:0] log_b_ext;
    logic [log_format_pkg::ext_log_w-1:0] log_sum;
    logic [log_format_pkg::ext_log_w-1:0] log_diff;
    logic signed [log_format_pkg::ext_log_w-1:0] ext_log_next;

    // both log words are non-negative, so zero extension keeps their value.
    assign log_a_ext = {{pad_w{1'b0}}, log_a};
    assign log_b_ext = {{pad_w{1'b0}}, log_b};

    // a full add, the mantissa carry or borrow runs into the characteristic.
    assign log_sum = log_a_ext + log_b_ext;
    assign log_diff = log_a_ext - log_b_ext;  // negative for a quotient below one.

    always_comb begin
        if (op == muldiv_op_pkg::op_div) begin
            ext_log_next = signed'(log_diff);
        end else begin
            ext_log_next = signed'(log_sum);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else if (en) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op_out <= op;
            ext_log <= ext_log_next;
            zero_a_out <= zero_a;
            zero_b_out <= zero_b;
        end
    end

endmodule

// ==== source/stage4_antilog.sv ====
`timescale 1ns/1ps

module stage4_antilog (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  muldiv_op_pkg::op_e op,
    input  logic signed [log_format_pkg::ext_log_w-1:0] ext_log,
    input  logic zero_a,
    input  logic zero_b,
    output logic valid_out,
    output logic [log_format_pkg::result_w-1:0] result,
    output logic div_by_zero
);

    localparam int ext_pad_w = log_format_pkg::shift_w - log_format_pkg::ext_int_w;

    logic valid_r0;
    logic [log_format_pkg::mant_w-1:0] mant_r0;
    logic signed [log_format_pkg::shift_w-1:0] shift_r0;
    logic [muldiv_op_pkg::spec_w-1:0] spec_r0;
    logic signed [log_format_pkg::ext_int_w-1:0] exp_part;
    logic signed [log_format_pkg::shift_w-1:0] shift_next;
    logic [muldiv_op_pkg::spec_w-1:0] spec_next;
    logic [log_format_pkg::shift_w-1:0] right_amt;
    logic [log_format_pkg::wide_w-1:0] wide;
    logic [log_format_pkg::result_w-1:0] lin_value;

    assign exp_part = signed'(ext_log[log_format_pkg::ext_log_w-1:log_format_pkg::log_frac_w]);

    // a quotient carries 16 fraction bits, so divides shift further left.
    always_comb begin
        shift_next = {{ext_pad_w{exp_part[log_format_pkg::ext_int_w-1]}}, exp_part};
        if (op == muldiv_op_pkg::op_div) begin
            shift_next = shift_next + log_format_pkg::shift_w'(log_format_pkg::quot_frac_w);
        end
    end

    always_comb begin
        if (op == muldiv_op_pkg::op_div && zero_b) begin
            spec_next = muldiv_op_pkg::spec_dbz;
        end else if (zero_a || (op == muldiv_op_pkg::op_mul && zero_b)) begin
            spec_next = muldiv_op_pkg::spec_zero;
        end else if (shift_next > log_format_pkg::shift_w'(log_format_pkg::max_shift)) begin
            spec_next = muldiv_op_pkg::spec_ovf;
        end else begin
            spec_next = muldiv_op_pkg::spec_none;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r0 <= 1'b0;
            valid_out <= 1'b0;
            result <= '0;
            div_by_zero <= 1'b0;
        end else if (en) begin
            valid_r0 <= valid_in;
            valid_out <= valid_r0;
            result <= (spec_r0 == muldiv_op_pkg::spec_none) ? lin_value
                    : (spec_r0 == muldiv_op_pkg::spec_zero) ? '0
                    : muldiv_op_pkg::sat_value;
            div_by_zero <= valid_r0 && (spec_r0 == muldiv_op_pkg::spec_dbz);
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            mant_r0 <= {1'b1, ext_log[log_format_pkg::log_frac_w-1:0]};
            shift_r0 <= shift_next;
            spec_r0 <= spec_next;
        end
    end

    // shift left then drop the fraction bits; a negative shift truncates to the right.
    assign right_amt = log_format_pkg::shift_w'(log_format_pkg::log_frac_w) - shift_r0;
    assign wide = log_format_pkg::wide_w'(mant_r0) << shift_r0[log_format_pkg::shift_w-2:0];

    always_comb begin
        if (shift_r0 < 0) begin
            lin_value = log_format_pkg::result_w'(mant_r0 >> right_amt);
        end else begin
            lin_value = wide[log_format_pkg::wide_w-1:log_format_pkg::log_frac_w];
        end
    end

endmodule

// ==== source/log_muldiv_top.sv ====
`timescale 1ns/1ps

module log_muldiv_top (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  muldiv_op_pkg::op_e op,
    input  logic [log_format_pkg::operand_w-1:0] in_0,
    input  logic [log_format_pkg::operand_w-1:0] in_1,
    output logic valid_out,
    output logic [log_format_pkg::result_w-1:0] result,
    output logic div_by_zero
);

    // stage 1 to stage 2.
    logic s1_valid;
    muldiv_op_pkg::op_e s1_op;
    logic [log_format_pkg::log_w-1:0] s1_log_a;
    logic [log_format_pkg::operand_w-1:0] s1_a;
    logic [log_format_pkg::operand_w-1:0] s1_b;

    // stage 2 to stage 3.
    logic s2_valid;
    muldiv_op_pkg::op_e s2_op;
    logic [log_format_pkg::log_w-1:0] s2_log_a;
    logic [log_format_pkg::log_w-1:0] s2_log_b;
    logic s2_zero_a;
    logic s2_zero_b;

    // stage 3 to stage 4.
    logic s3_valid;
    muldiv_op_pkg::op_e s3_op;
    logic signed [log_format_pkg::ext_log_w-1:0] s3_ext_log;
    logic s3_zero_a;
    logic s3_zero_b;

    stage1_log2_approx u_stage1 (
        .clk(clk), .rst(rst), .en(en),
        .valid_in(valid_in), .op(op), .in_0(in_0), .in_1(in_1),
        .valid_out(s1_valid), .op_out(s1_op), .log_in_0(s1_log_a),
        .in_0_bypass(s1_a), .in_1_bypass(s1_b)
    );

    stage2_log2_operand_b u_stage2 (
        .clk(clk), .rst(rst), .en(en),
        .valid_in(s1_valid), .op(s1_op), .log_in_0(s1_log_a),
        .in_0(s1_a), .in_1(s1_b),
        .valid_out(s2_valid), .op_out(s2_op), .log_a(s2_log_a), .log_b(s2_log_b),
        .zero_a(s2_zero_a), .zero_b(s2_zero_b)
    );

    stage3_log_combine u_stage3 (
        .clk(clk), .rst(rst), .en(en),
        .valid_in(s2_valid), .op(s2_op), .log_a(s2_log_a), .log_b(s2_log_b),
        .zero_a(s2_zero_a), .zero_b(s2_zero_b),
        .valid_out(s3_valid), .op_out(s3_op), .ext_log(s3_ext_log),
        .zero_a_out(s3_zero_a), .zero_b_out(s3_zero_b)
    );

    stage4_antilog u_stage4 (
        .clk(clk), .rst(rst), .en(en),
        .valid_in(s3_valid), .op(s3_op), .ext_log(s3_ext_log),
        .zero_a(s3_zero_a), .zero_b(s3_zero_b),
        .valid_out(valid_out), .result(result), .div_by_zero(div_by_zero)
    );

endmodule

// ==== dv/log_muldiv_tb.sv ====
`timescale 1ns/1ps

module log_muldiv_tb;

    localparam int latency = 8;       // enabled edges from input to output.
    localparam int drain_limit = 64;

    typedef struct packed {
        logic [31:0] due;
        logic [31:0] value;
        logic dbz;
        logic exact_chk;
        logic bound_chk;
        logic [63:0] exact;
    } expect_t;

    logic clk;
    logic rst;
    logic en;
    logic valid_in;
    muldiv_op_pkg::op_e op;
    logic [log_format_pkg::operand_w-1:0] in_0;
    logic [log_format_pkg::operand_w-1:0] in_1;
    logic valid_out;
    logic [log_format_pkg::result_w-1:0] result;
    logic div_by_zero;

    expect_t exp_q[$];
    logic [31:0] edge_cnt;
    logic exp_valid;
    logic [31:0] exp_result;
    logic exp_dbz;
    logic exp_exact_chk;
    logic exp_bound_chk;
    logic [63:0] exp_exact;
    logic prev_en;
    logic prev_valid;
    logic [31:0] prev_result;

    log_muldiv_top UUT (
        .clk(clk), .rst(rst), .en(en),
        .valid_in(valid_in), .op(op), .in_0(in_0), .in_1(in_1),
        .valid_out(valid_out), .result(result), .div_by_zero(div_by_zero)
    );

    always begin
        clk = 1'b0;
        #4;
        clk = 1'b1;
        #4;
    end

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("SIMULATION FAILED");
        $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, expected, actual);
        $fatal(1, "%s does not match the model", name);
    endtask

    task automatic report_timeout(string what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout: %s", what);
    endtask

    // index of the highest set bit, -1 for zero.
    function automatic int leading_one(logic [15:0] x);
        int pos;
        pos = -1;
        for (int i = 0; i < 16; i++) begin
            if (x[i]) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    function automatic logic [15:0] log_word(logic [15:0] x);
        int k;
        logic [11:0] frac;
        k = leading_one(x);
        frac = '0;
        if (k < 0) begin
            return '0;
        end
        for (int i = 1; i <= 12; i++) begin
            if (k - i >= 0) begin
                frac[12 - i] = x[k - i];  // bits below bit 0 stay zero.
            end
        end
        return {4'(k), frac};
    endfunction

    function automatic logic [31:0] antilog_value(int l, bit is_div);
        int e;
        int s;
        logic [63:0] m;
        logic [63:0] v;
        e = l >>> 12;
        s = e + (is_div ? 16 : 0);
        m = 64'(4096 + (l & 32'h0fff));
        if (s < 0) begin
            v = m >> (12 - s);
        end else begin
            v = (m << s) >> 12;
        end
        if (s > 40 || v > 64'hffff_ffff) begin
            return muldiv_op_pkg::sat_value;
        end
        return v[31:0];
    endfunction

    function automatic logic [31:0] model_value(muldiv_op_pkg::op_e o, logic [15:0] a,
                                                logic [15:0] b);
        int la;
        int lb;
        la = int'(log_word(a));
        lb = int'(log_word(b));
        if (o == muldiv_op_pkg::op_div && b == 0) begin
            return muldiv_op_pkg::sat_value;
        end
        if (a == 0 || b == 0) begin
            return '0;
        end
        if (o == muldiv_op_pkg::op_mul) begin
            return antilog_value(la + lb, 1'b0);
        end
        return antilog_value(la - lb, 1'b1);
    endfunction

    function automatic bit is_power_of_two(logic [15:0] x);
        return (x != 0) && ((x & (x - 16'd1)) == 0);
    endfunction

    function automatic logic [15:0] random_operand();
        int pick;
        pick = $urandom % 10;
        if (pick == 0) begin
            return 16'hffff;
        end
        if (pick == 1) begin
            return 16'(1) << ($urandom % 16);
        end
        if (pick == 2) begin
            return 16'(1 + $urandom % 255);  // small operands.
        end
        return 16'($urandom);
    endfunction

    function automatic muldiv_op_pkg::op_e random_op();
        return ($urandom % 2 == 0) ? muldiv_op_pkg::op_mul : muldiv_op_pkg::op_div;
    endfunction

    task automatic send_sample(muldiv_op_pkg::op_e o, logic [15:0] a, logic [15:0] b);
        expect_t item;
        @(negedge clk);
        en = 1'b1;
        valid_in = 1'b1;
        op = o;
        in_0 = a;
        in_1 = b;
        item.due = edge_cnt + latency;
        item.value = model_value(o, a, b);
        item.dbz = (o == muldiv_op_pkg::op_div) && (b == 0);
        item.exact_chk = is_power_of_two(a) && is_power_of_two(b);
        item.bound_chk = (o == muldiv_op_pkg::op_mul) && (a != 0) && (b != 0);
        if (o == muldiv_op_pkg::op_mul) begin
            item.exact = 64'(a) * 64'(b);
        end else begin
            item.exact = (b == 0) ? 64'd0 : (64'(a) << 16) / 64'(b);
        end
        exp_q.push_back(item);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        en = 1'b1;
        valid_in = 1'b0;
        in_0 = 16'($urandom);
        in_1 = 16'($urandom);
    endtask

    // nothing may be captured while en is low, even with valid_in high.
    task automatic stall_cycle();
        @(negedge clk);
        en = 1'b0;
        valid_in = 1'($urandom);
        op = random_op();
        in_0 = 16'($urandom);
        in_1 = 16'($urandom);
    endtask

    task automatic drain_pipeline();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_limit) begin
            drive_idle();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("pipeline did not deliver every expected result");
        end else begin
            drive_idle();
            drive_idle();
        end
    endtask

    // the model outputs follow the DUT, one enabled edge per step.
    always @(posedge clk) begin
        expect_t head;
        prev_en <= en;
        prev_valid <= valid_out;
        prev_result <= result;
        if (rst) begin
            edge_cnt <= '0;
            exp_valid <= 1'b0;
            exp_result <= '0;
            exp_dbz <= 1'b0;
            exp_exact_chk <= 1'b0;
            exp_bound_chk <= 1'b0;
            exp_exact <= '0;
        end else if (en) begin
            edge_cnt <= edge_cnt + 1;
            if (exp_q.size() != 0 && exp_q[0].due == edge_cnt + 1) begin
                head = exp_q.pop_front();
                exp_valid <= 1'b1;
                exp_result <= head.value;
                exp_dbz <= head.dbz;
                exp_exact_chk <= head.exact_chk;
                exp_bound_chk <= head.bound_chk;
                exp_exact <= head.exact;
            end else begin
                exp_valid <= 1'b0;
                exp_dbz <= 1'b0;
            end
        end
    end

    valid_matches: assert property (@(posedge clk) disable iff (rst)
        valid_out === exp_valid)
        else report_mismatch("valid_out", $sampled(exp_valid), $sampled(valid_out));

    result_matches: assert property (@(posedge clk) disable iff (rst)
        (valid_out && exp_valid) |-> result === exp_result)
        else report_mismatch("result", $sampled(exp_result), $sampled(result));

    dbz_matches: assert property (@(posedge clk) disable iff (rst)
        div_by_zero === exp_dbz)
        else report_mismatch("div_by_zero", $sampled(exp_dbz), $sampled(div_by_zero));

    exact_matches: assert property (@(posedge clk) disable iff (rst)
        (valid_out && exp_valid && exp_exact_chk) |-> 64'(result) == exp_exact)
        else report_mismatch("result (exact power of two)", $sampled(exp_exact),
                             $sampled(result));

    // the approximation never overshoots and stays within 11.2 percent below.
    bound_holds: assert property (@(posedge clk) disable iff (rst)
        (valid_out && exp_valid && exp_bound_chk) |->
            (64'(result) <= exp_exact) && (64'(result) * 64'd10000 >= exp_exact * 64'd8880))
        else report_mismatch("result (error bound)", $sampled(exp_exact), $sampled(result));

    hold_valid: assert property (@(posedge clk) disable iff (rst)
        (prev_en === 1'b0) |-> valid_out === prev_valid)
        else report_mismatch("valid_out (stall)", $sampled(prev_valid), $sampled(valid_out));

    hold_result: assert property (@(posedge clk) disable iff (rst)
        (prev_en === 1'b0) |-> result === prev_result)
        else report_mismatch("result (stall)", $sampled(prev_result), $sampled(result));

    initial begin
        int pick;
        logic [15:0] b;
        void'($urandom(32'h121e));
        rst = 1'b1;
        en = 1'b1;
        valid_in = 1'b0;
        op = muldiv_op_pkg::op_mul;
        in_0 = '0;
        in_1 = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs stay quiet while only bubbles travel.
        repeat (12) drive_idle();

        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                send_sample(muldiv_op_pkg::op_mul, 16'(1) << i, 16'(1) << j);
            end
        end
        send_sample(muldiv_op_pkg::op_mul, 16'hffff, 16'hffff);
        send_sample(muldiv_op_pkg::op_mul, 16'hffff, 16'h0001);
        send_sample(muldiv_op_pkg::op_mul, 16'h0003, 16'hffff);
        for (int n = 0; n < 150; n++) begin
            send_sample(muldiv_op_pkg::op_mul, random_operand(), random_operand());
        end
        drain_pipeline();

        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                send_sample(muldiv_op_pkg::op_div, 16'(1) << i, 16'(1) << j);
            end
        end
        for (int n = 0; n < 150; n++) begin
            b = random_operand();
            if (b == 0) begin
                b = 16'd1;
            end
            send_sample(muldiv_op_pkg::op_div, random_operand(), b);
        end
        send_sample(muldiv_op_pkg::op_div, 16'h0000, 16'h0007);
        send_sample(muldiv_op_pkg::op_div, 16'h0000, 16'hffff);
        drain_pipeline();

        send_sample(muldiv_op_pkg::op_mul, 16'h0000, random_operand());
        send_sample(muldiv_op_pkg::op_mul, 16'h1234, 16'h0000);
        send_sample(muldiv_op_pkg::op_mul, 16'h0000, 16'h0000);
        send_sample(muldiv_op_pkg::op_div, 16'hbeef, 16'h0000);
        send_sample(muldiv_op_pkg::op_div, 16'h0000, 16'h0000);
        send_sample(muldiv_op_pkg::op_div, 16'hffff, 16'h0000);
        drain_pipeline();

        // random stalls and bubbles between live samples.
        for (int n = 0; n < 400; n++) begin
            pick = $urandom % 4;
            if (pick == 0) begin
                stall_cycle();
            end else if (pick == 1) begin
                drive_idle();
            end else begin
                send_sample(random_op(), random_operand(), random_operand());
            end
        end
        drain_pipeline();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== log_muldiv.f ====
source/log_format_pkg.sv
source/muldiv_op_pkg.sv
source/stage1_log2_approx.sv
source/stage2_log2_operand_b.sv
source/stage3_log_combine.sv
source/stage4_antilog.sv
source/log_muldiv_top.sv
dv/log_muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: log_muldiv

sources:
  - source/log_format_pkg.sv
  - source/muldiv_op_pkg.sv
  - source/stage1_log2_approx.sv
  - source/stage2_log2_operand_b.sv
  - source/stage3_log_combine.sv
  - source/stage4_antilog.sv
  - source/log_muldiv_top.sv
  - target: test
    files:
      - dv/log_muldiv_tb.sv
